//--- hw/rvv_shift_consts.svh
`ifndef RVV_SHIFT_CONSTS_SVH
`define RVV_SHIFT_CONSTS_SVH

// vector register geometry
`define VLEN 64
`define VLENB 8

// scalar register width
`define XLEN 32

// element widths
`define BYTE_WIDTH 8
`define HWORD_WIDTH 16
`define WORD_WIDTH 32

// rob tag and micro-op index
`define ROB_DEPTH_WIDTH 4
`define UOP_INDEX_WIDTH 3

`endif

//--- hw/rvv_shift_pkg.sv
`default_nettype none

package rvv_shift_pkg;

  // operand form in the funct3 field
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } opi_funct3_e;

  typedef enum logic [5:0] {
    VSLL    = 6'b100101,
    VSRL    = 6'b101000,
    VSRA    = 6'b101001,
    VSSRL   = 6'b101010,
    VSSRA   = 6'b101011,
    VNSRL   = 6'b101100,
    VNSRA   = 6'b101101,
    VNCLIPU = 6'b101110,
    VNCLIP  = 6'b101111
  } shift_funct6_e;

  typedef enum logic [1:0] {
    SHIFT_SLL = 2'd0,
    SHIFT_SRL = 2'd1,
    SHIFT_SRA = 2'd2
  } shift_op_e;

  typedef enum logic [1:0] {
    KIND_PLAIN   = 2'd0,
    KIND_SCALING = 2'd1,
    KIND_NARROW  = 2'd2,
    KIND_CLIP    = 2'd3
  } shift_kind_e;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  // fixed-point rounding mode in vxrm csr encoding
  typedef enum logic [1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } vxrm_e;

endpackage

`default_nettype wire

//--- hw/shift_uop_decode.sv
`include "rvv_shift_consts.svh"

`default_nettype none

module shift_uop_decode (
  input  logic                         uop_valid,
  input  rvv_shift_pkg::opi_funct3_e   funct3,
  input  rvv_shift_pkg::shift_funct6_e funct6,
  input  rvv_shift_pkg::eew_e          vs2_eew,
  input  logic                         vs1_valid,
  input  logic                         vs2_valid,
  input  logic                         rs1_valid,
  input  logic [`VLEN-1:0]             vs1_data,
  input  logic [`XLEN-1:0]             rs1_data,
  output logic                         accept,
  output rvv_shift_pkg::shift_op_e     op,
  output rvv_shift_pkg::shift_kind_e   kind,
  output logic [`VLEN-1:0]             amount_data
);
  import rvv_shift_pkg::*;

  logic known_op;
  logic src_ok;
  logic eew_ok;

  // funct6 to shift direction and result kind
  always_comb begin
    known_op = 1'b1;
    op       = SHIFT_SLL;
    kind     = KIND_PLAIN;
    case (funct6)
      VSLL: begin
        op = SHIFT_SLL;
      end
      VSRL: begin
        op = SHIFT_SRL;
      end
      VSRA: begin
        op = SHIFT_SRA;
      end
      VSSRL, VSSRA: begin
        op   = (funct6 == VSSRA) ? SHIFT_SRA : SHIFT_SRL;
        kind = KIND_SCALING;
      end
      VNSRL, VNSRA: begin
        op   = (funct6 == VNSRA) ? SHIFT_SRA : SHIFT_SRL;
        kind = KIND_NARROW;
      end
      VNCLIPU, VNCLIP: begin
        op   = (funct6 == VNCLIP) ? SHIFT_SRA : SHIFT_SRL;
        kind = KIND_CLIP;
      end
      default: begin
        known_op = 1'b0;
      end
    endcase
  end

  // shift amount source must be present
  always_comb begin
    case (funct3)
      OPIVV:        src_ok = vs1_valid;
      OPIVX, OPIVI: src_ok = rs1_valid;
      default:      src_ok = 1'b0;
    endcase
  end

  // narrowing forms need a wide source element
  always_comb begin
    case (vs2_eew)
      EEW8:         eew_ok = (kind == KIND_PLAIN) || (kind == KIND_SCALING);
      EEW16, EEW32: eew_ok = 1'b1;
      default:      eew_ok = 1'b0;
    endcase
  end

  assign accept = uop_valid & known_op & vs2_valid & src_ok & eew_ok;

  // scalar amount is splatted per element slot
  always_comb begin
    if (funct3 == OPIVV) begin
      amount_data = vs1_data;
    end else begin
      case (vs2_eew)
        EEW8:    amount_data = {`VLENB{rs1_data[`BYTE_WIDTH-1:0]}};
        EEW16:   amount_data = {(`VLEN/`HWORD_WIDTH){rs1_data[`HWORD_WIDTH-1:0]}};
        default: amount_data = {(`VLEN/`WORD_WIDTH){rs1_data[`WORD_WIDTH-1:0]}};
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/shift_lane.sv
`default_nettype none

module shift_lane #(
  parameter int lane_width = 8
) (
  input  rvv_shift_pkg::shift_op_e      op,
  input  rvv_shift_pkg::vxrm_e          vxrm,
  input  logic [lane_width-1:0]         operand,
  input  logic [$clog2(lane_width)-1:0] amount,
  output logic [lane_width-1:0]         shifted,
  output logic [lane_width-1:0]         rounded,
  output logic                          carry
);
  import rvv_shift_pkg::*;

  logic [2*lane_width-1:0] wide;
  logic [lane_width-1:0]   dropped;
  logic                    increment;
  logic                    ext_bit;

  // operand sits in the upper half, dropped bits fall into the lower half
  always_comb begin
    case (op)
      SHIFT_SLL: wide = {operand, {lane_width{1'b0}}} << amount;
      SHIFT_SRL: wide = {operand, {lane_width{1'b0}}} >> amount;
      SHIFT_SRA: wide = $signed({operand, {lane_width{1'b0}}}) >>> amount;
      default:   wide = '0;
    endcase
  end

  assign shifted = wide[2*lane_width-1 -: lane_width];
  assign dropped = wide[lane_width-1:0];

  // rounding increment per vxrm
  always_comb begin
    case (vxrm)
      RNU:     increment = dropped[lane_width-1];
      RNE:     increment = dropped[lane_width-1] &
                           ((|dropped[lane_width-2:0]) | shifted[0]);
      RDN:     increment = 1'b0;
      ROD:     increment = ~shifted[0] & (|dropped);
      default: increment = 1'b0;
    endcase
  end

  // carry is the sign of the rounded value for sra
  assign ext_bit = (op == SHIFT_SRA) & shifted[lane_width-1];

  assign {carry, rounded} = {ext_bit, shifted} + {{lane_width{1'b0}}, increment};

endmodule

`default_nettype wire

//--- hw/shift_narrow_clip.sv
`include "rvv_shift_consts.svh"

`default_nettype none

module shift_narrow_clip (
  input  rvv_shift_pkg::shift_op_e        op,
  input  rvv_shift_pkg::eew_e             vs2_eew,
  input  logic [`VLEN-1:0]                rounded16,
  input  logic [`VLEN/`HWORD_WIDTH-1:0]   carry16,
  input  logic [`VLEN-1:0]                rounded32,
  input  logic [`VLEN/`WORD_WIDTH-1:0]    carry32,
  output logic [`VLEN/2-1:0]              clipped,
  output logic                            saturated
);
  import rvv_shift_pkg::*;

  logic [1:0][`VLEN/2-1:0] clip_grp;
  logic [1:0]              sat_grp;

  genvar g, e;
  generate
    // group 0 narrows 16 to 8, group 1 narrows 32 to 16
    for (g = 0; g < 2; g++) begin : grp
      localparam int w = (g == 0) ? `HWORD_WIDTH : `WORD_WIDTH;
      localparam int h = w / 2;
      localparam int n = `VLEN / w;

      logic [`VLEN-1:0] rnd;
      logic [n-1:0]     cy;
      logic [n-1:0]     ovf;

      if (g == 0) begin : src
        assign rnd = rounded16;
        assign cy  = carry16;
      end else begin : src
        assign rnd = rounded32;
        assign cy  = carry32;
      end

      for (e = 0; e < n; e++) begin : elem
        logic         pos;
        logic         neg;
        logic [h-1:0] narrow;

        // range check on the upper half plus carry
        always_comb begin
          if (op == SHIFT_SRA) begin
            pos = ~cy[e] & ((|rnd[e*w+h +: h]) | rnd[e*w+h-1]);
            neg = cy[e] & ~((&rnd[e*w+h +: h]) & rnd[e*w+h-1]);
          end else begin
            pos = cy[e] | (|rnd[e*w+h +: h]);
            neg = 1'b0;
          end
        end

        always_comb begin
          if (pos && (op == SHIFT_SRA)) begin
            narrow = {1'b0, {(h-1){1'b1}}};
          end else if (pos) begin
            narrow = {h{1'b1}};
          end else if (neg) begin
            narrow = {1'b1, {(h-1){1'b0}}};
          end else begin
            narrow = rnd[e*w +: h];
          end
        end

        assign clip_grp[g][e*h +: h] = narrow;
        assign ovf[e] = pos | neg;
      end

      assign sat_grp[g] = |ovf;
    end
  endgenerate

  always_comb begin
    case (vs2_eew)
      EEW16: begin
        clipped   = clip_grp[0];
        saturated = sat_grp[0];
      end
      EEW32: begin
        clipped   = clip_grp[1];
        saturated = sat_grp[1];
      end
      default: begin
        clipped   = '0;
        saturated = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/shift_result_pack.sv
`include "rvv_shift_consts.svh"

`default_nettype none

module shift_result_pack (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          accept,
  input  rvv_shift_pkg::shift_kind_e    kind,
  input  rvv_shift_pkg::eew_e           vs2_eew,
  input  logic [`UOP_INDEX_WIDTH-1:0]   uop_index,
  input  logic [`ROB_DEPTH_WIDTH-1:0]   rob_entry,
  input  logic [`VLEN-1:0]              shifted8,
  input  logic [`VLEN-1:0]              shifted16,
  input  logic [`VLEN-1:0]              shifted32,
  input  logic [`VLEN-1:0]              rounded8,
  input  logic [`VLEN-1:0]              rounded16,
  input  logic [`VLEN-1:0]              rounded32,
  input  logic [`VLEN/2-1:0]            clipped,
  input  logic                          saturated,
  output logic                          result_valid,
  output logic [`VLEN-1:0]              w_data,
  output logic                          vxsat,
  output logic [`ROB_DEPTH_WIDTH-1:0]   result_rob_entry
);
  import rvv_shift_pkg::*;

  logic [`VLEN-1:0]   grp_shifted;
  logic [`VLEN-1:0]   grp_rounded;
  logic [`VLEN/2-1:0] narrowed;
  logic [`VLEN/2-1:0] narrow_src;
  logic [`VLEN-1:0]   next_data;
  logic               next_vxsat;

  // width group for full-width results
  always_comb begin
    case (vs2_eew)
      EEW8: begin
        grp_shifted = shifted8;
        grp_rounded = rounded8;
      end
      EEW16: begin
        grp_shifted = shifted16;
        grp_rounded = rounded16;
      end
      default: begin
        grp_shifted = shifted32;
        grp_rounded = rounded32;
      end
    endcase
  end

  // low half of every wide element
  always_comb begin
    narrowed = '0;
    if (vs2_eew == EEW16) begin
      for (int i = 0; i < `VLEN/`HWORD_WIDTH; i++) begin
        narrowed[i*`BYTE_WIDTH +: `BYTE_WIDTH] = shifted16[i*`HWORD_WIDTH +: `BYTE_WIDTH];
      end
    end else if (vs2_eew == EEW32) begin
      for (int i = 0; i < `VLEN/`WORD_WIDTH; i++) begin
        narrowed[i*`HWORD_WIDTH +: `HWORD_WIDTH] = shifted32[i*`WORD_WIDTH +: `HWORD_WIDTH];
      end
    end
  end

  assign narrow_src = (kind == KIND_CLIP) ? clipped : narrowed;

  // uop_index bit 0 picks the destination half
  always_comb begin
    case (kind)
      KIND_PLAIN:   next_data = grp_shifted;
      KIND_SCALING: next_data = grp_rounded;
      default: begin
        if (uop_index[0]) begin
          next_data = {narrow_src, {(`VLEN/2){1'b0}}};
        end else begin
          next_data = {{(`VLEN/2){1'b0}}, narrow_src};
        end
      end
    endcase
  end

  assign next_vxsat = (kind == KIND_CLIP) & saturated;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      vxsat        <= 1'b0;
    end else begin
      result_valid <= accept;
      vxsat        <= accept & next_vxsat;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      w_data           <= next_data;
      result_rob_entry <= rob_entry;
    end
  end

endmodule

`default_nettype wire

//--- hw/rvv_shift_unit.sv
`include "rvv_shift_consts.svh"

`default_nettype none

module rvv_shift_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          uop_valid,
  input  rvv_shift_pkg::opi_funct3_e    funct3,
  input  rvv_shift_pkg::shift_funct6_e  funct6,
  input  rvv_shift_pkg::vxrm_e          vxrm,
  input  rvv_shift_pkg::eew_e           vs2_eew,
  input  logic [`VLEN-1:0]              vs1_data,
  input  logic                          vs1_valid,
  input  logic [`VLEN-1:0]              vs2_data,
  input  logic                          vs2_valid,
  input  logic [`XLEN-1:0]              rs1_data,
  input  logic                          rs1_valid,
  input  logic [`UOP_INDEX_WIDTH-1:0]   uop_index,
  input  logic [`ROB_DEPTH_WIDTH-1:0]   rob_entry,
  output logic                          result_valid,
  output logic [`VLEN-1:0]              w_data,
  output logic                          vxsat,
  output logic [`ROB_DEPTH_WIDTH-1:0]   result_rob_entry
);
  import rvv_shift_pkg::*;

  logic                          accept;
  shift_op_e                     op;
  shift_kind_e                   kind;
  logic [`VLEN-1:0]              amount_data;
  logic [`VLEN-1:0]              shifted8;
  logic [`VLEN-1:0]              shifted16;
  logic [`VLEN-1:0]              shifted32;
  logic [`VLEN-1:0]              rounded8;
  logic [`VLEN-1:0]              rounded16;
  logic [`VLEN-1:0]              rounded32;
  logic [`VLEN/`HWORD_WIDTH-1:0] carry16;
  logic [`VLEN/`WORD_WIDTH-1:0]  carry32;
  logic [`VLEN/2-1:0]            clipped;
  logic                          saturated;

  shift_uop_decode u_decode (
    .uop_valid   (uop_valid),
    .funct3      (funct3),
    .funct6      (funct6),
    .vs2_eew     (vs2_eew),
    .vs1_valid   (vs1_valid),
    .vs2_valid   (vs2_valid),
    .rs1_valid   (rs1_valid),
    .vs1_data    (vs1_data),
    .rs1_data    (rs1_data),
    .accept      (accept),
    .op          (op),
    .kind        (kind),
    .amount_data (amount_data)
  );

  // all three width groups run in parallel, pack picks one
  genvar j;
  generate
    for (j = 0; j < `VLENB; j++) begin : lane8
      shift_lane #(.lane_width(`BYTE_WIDTH)) u_lane (
        .op      (op),
        .vxrm    (vxrm),
        .operand (vs2_data[j*`BYTE_WIDTH +: `BYTE_WIDTH]),
        .amount  (amount_data[j*`BYTE_WIDTH +: $clog2(`BYTE_WIDTH)]),
        .shifted (shifted8[j*`BYTE_WIDTH +: `BYTE_WIDTH]),
        .rounded (rounded8[j*`BYTE_WIDTH +: `BYTE_WIDTH]),
        .carry   ()
      );
    end

    for (j = 0; j < `VLEN/`HWORD_WIDTH; j++) begin : lane16
      shift_lane #(.lane_width(`HWORD_WIDTH)) u_lane (
        .op      (op),
        .vxrm    (vxrm),
        .operand (vs2_data[j*`HWORD_WIDTH +: `HWORD_WIDTH]),
        .amount  (amount_data[j*`HWORD_WIDTH +: $clog2(`HWORD_WIDTH)]),
        .shifted (shifted16[j*`HWORD_WIDTH +: `HWORD_WIDTH]),
        .rounded (rounded16[j*`HWORD_WIDTH +: `HWORD_WIDTH]),
        .carry   (carry16[j])
      );
    end

    for (j = 0; j < `VLEN/`WORD_WIDTH; j++) begin : lane32
      shift_lane #(.lane_width(`WORD_WIDTH)) u_lane (
        .op      (op),
        .vxrm    (vxrm),
        .operand (vs2_data[j*`WORD_WIDTH +: `WORD_WIDTH]),
        .amount  (amount_data[j*`WORD_WIDTH +: $clog2(`WORD_WIDTH)]),
        .shifted (shifted32[j*`WORD_WIDTH +: `WORD_WIDTH]),
        .rounded (rounded32[j*`WORD_WIDTH +: `WORD_WIDTH]),
        .carry   (carry32[j])
      );
    end
  endgenerate

  shift_narrow_clip u_clip (
    .op        (op),
    .vs2_eew   (vs2_eew),
    .rounded16 (rounded16),
    .carry16   (carry16),
    .rounded32 (rounded32),
    .carry32   (carry32),
    .clipped   (clipped),
    .saturated (saturated)
  );

  shift_result_pack u_pack (
    .clk              (clk),
    .rst              (rst),
    .accept           (accept),
    .kind             (kind),
    .vs2_eew          (vs2_eew),
    .uop_index        (uop_index),
    .rob_entry        (rob_entry),
    .shifted8         (shifted8),
    .shifted16        (shifted16),
    .shifted32        (shifted32),
    .rounded8         (rounded8),
    .rounded16        (rounded16),
    .rounded32        (rounded32),
    .clipped          (clipped),
    .saturated        (saturated),
    .result_valid     (result_valid),
    .w_data           (w_data),
    .vxsat            (vxsat),
    .result_rob_entry (result_rob_entry)
  );

endmodule

`default_nettype wire

//--- sim/rvv_shift_unit_properties.sv
`default_nettype none

module rvv_shift_unit_properties (
  input logic                         clk,
  input logic                         rst,
  input logic                         uop_valid,
  input rvv_shift_pkg::opi_funct3_e   funct3,
  input rvv_shift_pkg::shift_funct6_e funct6,
  input rvv_shift_pkg::eew_e          vs2_eew,
  input logic                         vs1_valid,
  input logic                         vs2_valid,
  input logic                         rs1_valid,
  input logic                         result_valid,
  input logic                         vxsat
);
  timeunit 1ns;
  timeprecision 1ps;
  import rvv_shift_pkg::*;

  int   failures = 0;
  logic src_present;
  logic known_op;
  logic narrow_op;
  logic clip_op;
  logic width_ok;
  logic issue_ok;

  // acceptance rule rebuilt from the issue ports
  assign src_present = (funct3 == OPIVV) ? vs1_valid :
                       ((funct3 == OPIVX) || (funct3 == OPIVI)) && rs1_valid;
  assign known_op = funct6 inside {VSLL, VSRL, VSRA, VSSRL, VSSRA,
                                   VNSRL, VNSRA, VNCLIPU, VNCLIP};
  assign narrow_op = funct6 inside {VNSRL, VNSRA, VNCLIPU, VNCLIP};
  assign clip_op = funct6 inside {VNCLIPU, VNCLIP};
  assign width_ok = (vs2_eew inside {EEW16, EEW32}) || (!narrow_op && (vs2_eew == EEW8));
  assign issue_ok = uop_valid && vs2_valid && src_present && known_op && width_ok;

  // output register clears on reset
  a_reset_clear: assert property (@(posedge clk) rst |=> !result_valid && !vxsat)
  else begin
    failures++;
    $error("result_valid or vxsat high in the cycle after reset");
  end

  a_accept_result: assert property (@(posedge clk) disable iff (rst)
    issue_ok |=> result_valid)
  else begin
    failures++;
    $error("accepted micro-op gave no result_valid one cycle later");
  end

  // rejected or idle cycles produce nothing
  a_no_result: assert property (@(posedge clk) disable iff (rst)
    !issue_ok |=> !result_valid)
  else begin
    failures++;
    $error("result_valid high without an accepted micro-op");
  end

  // only a clip micro-op can saturate
  a_vxsat_valid: assert property (@(posedge clk) disable iff (rst)
    vxsat |-> result_valid && $past(clip_op))
  else begin
    failures++;
    $error("vxsat high without a clip result");
  end

endmodule

bind rvv_shift_unit rvv_shift_unit_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .uop_valid    (uop_valid),
  .funct3       (funct3),
  .funct6       (funct6),
  .vs2_eew      (vs2_eew),
  .vs1_valid    (vs1_valid),
  .vs2_valid    (vs2_valid),
  .rs1_valid    (rs1_valid),
  .result_valid (result_valid),
  .vxsat        (vxsat)
);

`default_nettype wire

//--- sim/rvv_shift_unit_tb.sv
`include "rvv_shift_consts.svh"

`default_nettype none

module rvv_shift_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rvv_shift_pkg::*;

  localparam int n_plain    = 60;
  localparam int n_scaling  = 48;
  localparam int n_narrow   = 32;
  localparam int n_clip     = 32;
  localparam int n_reject   = 40;
  localparam int total_uops = n_plain + n_scaling + n_narrow + n_clip + n_reject;
  // twice the run of one cycle per uop plus drain and reset cycles
  localparam int watchdog_ns = 2 * 4 * (total_uops + 5 * 4 + 10);

  logic                        clk;
  logic                        rst;
  logic                        uop_valid;
  opi_funct3_e                 funct3;
  shift_funct6_e               funct6;
  vxrm_e                       vxrm;
  eew_e                        vs2_eew;
  logic [`VLEN-1:0]            vs1_data;
  logic                        vs1_valid;
  logic [`VLEN-1:0]            vs2_data;
  logic                        vs2_valid;
  logic [`XLEN-1:0]            rs1_data;
  logic                        rs1_valid;
  logic [`UOP_INDEX_WIDTH-1:0] uop_index;
  logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
  logic                        result_valid;
  logic [`VLEN-1:0]            w_data;
  logic                        vxsat;
  logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry;

  // expected results in issue order
  logic [`VLEN-1:0]            exp_data[$];
  logic                        exp_sat[$];
  logic [`ROB_DEPTH_WIDTH-1:0] exp_rob[$];
  int                          exp_due[$];

  int    cyc = 0;
  int    errors = 0;
  int    start_errors = 0;
  int    uops_run = 0;
  int    tests_run = 0;
  string test_name = "reset";

  shift_funct6_e plain_ops[3] = '{VSLL, VSRL, VSRA};
  opi_funct3_e   forms[3] = '{OPIVV, OPIVX, OPIVI};
  eew_e          widths[3] = '{EEW8, EEW16, EEW32};

  rvv_shift_unit u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [`VLEN-1:0] rand_vec();
    return {$urandom, $urandom};
  endfunction

  // shifts one element and returns the shifted value plus rounding increment
  function automatic longint round_shift(input bit left, input bit arith, input vxrm_e rm,
                                         input longint x, input int w, input int s,
                                         output longint shifted);
    longint v;
    bit     half;
    bit     low;
    bit     lsb;
    bit     inc;
    v = x;
    if (arith && x[w-1]) begin
      v = x - (longint'(1) << w);
    end
    if (left) begin
      shifted = v << s;
      return shifted;
    end
    shifted = v >>> s;
    lsb = shifted[0];
    half = 1'b0;
    low = 1'b0;
    if (s > 0) begin
      half = v[s-1];
    end
    if (s > 1) begin
      low = (v & ((longint'(1) << (s - 1)) - 1)) != 0;
    end
    case (rm)
      RNU:     inc = half;
      RNE:     inc = half & (low | lsb);
      RDN:     inc = 1'b0;
      default: inc = ~lsb & (half | low);
    endcase
    return shifted + inc;
  endfunction

  // reference model returning {vxsat, w_data}
  function automatic logic [`VLEN:0] model(input shift_funct6_e f6, input opi_funct3_e f3,
                                           input vxrm_e rm, input eew_e eew,
                                           input logic [`VLEN-1:0] vs1,
                                           input logic [`VLEN-1:0] vs2,
                                           input logic [`XLEN-1:0] rs1,
                                           input logic [`UOP_INDEX_WIDTH-1:0] idx);
    int                 w;
    int                 h;
    int                 s;
    bit                 arith;
    bit                 narrow;
    bit                 clip;
    longint             x;
    longint             sh;
    longint             full;
    longint             lim_hi;
    longint             lim_lo;
    logic [`VLEN-1:0]   res;
    logic [`VLEN/2-1:0] half_res;
    logic               sat;
    w = (eew == EEW8) ? 8 : (eew == EEW16) ? 16 : 32;
    h = w / 2;
    arith = f6 inside {VSRA, VSSRA, VNSRA, VNCLIP};
    narrow = f6 inside {VNSRL, VNSRA};
    clip = f6 inside {VNCLIPU, VNCLIP};
    res = '0;
    half_res = '0;
    sat = 1'b0;
    for (int e = 0; e < `VLEN / w; e++) begin
      x = (vs2 >> (e * w)) & ((longint'(1) << w) - 1);
      s = (f3 == OPIVV) ? ((vs1 >> (e * w)) & (w - 1)) : (rs1 & (w - 1));
      full = round_shift(f6 == VSLL, arith, rm, x, w, s, sh);
      if (clip) begin
        lim_hi = arith ? (longint'(1) << (h - 1)) - 1 : (longint'(1) << h) - 1;
        lim_lo = arith ? -(longint'(1) << (h - 1)) : 0;
        if (full > lim_hi) begin
          full = lim_hi;
          sat = 1'b1;
        end else if (full < lim_lo) begin
          full = lim_lo;
          sat = 1'b1;
        end
        half_res = half_res | ((full & ((longint'(1) << h) - 1)) << (e * h));
      end else if (narrow) begin
        half_res = half_res | ((sh & ((longint'(1) << h) - 1)) << (e * h));
      end else if (f6 inside {VSSRL, VSSRA}) begin
        res = res | ((full & ((longint'(1) << w) - 1)) << (e * w));
      end else begin
        res = res | ((sh & ((longint'(1) << w) - 1)) << (e * w));
      end
    end
    if (narrow || clip) begin
      res = idx[0] ? {half_res, {(`VLEN/2){1'b0}}} : {{(`VLEN/2){1'b0}}, half_res};
    end
    return {sat, res};
  endfunction

  // out of range elements get top bits 01 or 10 and in range ones extend a narrow value
  function automatic logic [`VLEN-1:0] clip_operand(input eew_e eew, input bit sgn,
                                                    input bit out);
    logic [`VLEN-1:0] v;
    longint           e_val;
    int               w;
    w = (eew == EEW16) ? 16 : 32;
    v = '0;
    for (int e = 0; e < `VLEN / w; e++) begin
      e_val = $urandom & ((longint'(1) << (w / 2)) - 1);
      if (out) begin
        e_val = $urandom & ((longint'(1) << (w - 2)) - 1);
        e_val = e_val | (longint'($urandom_range(1, 2)) << (w - 2));
      end else if (sgn && e_val[w/2-1]) begin
        e_val = e_val | (((longint'(1) << w) - 1) & ~((longint'(1) << (w / 2)) - 1));
      end
      v = v | (e_val << (e * w));
    end
    return v;
  endfunction

  // valids is {vs1_valid, vs2_valid, rs1_valid}
  task automatic issue(input shift_funct6_e f6, input opi_funct3_e f3, input vxrm_e rm,
                       input eew_e eew, input logic [`VLEN-1:0] vs1,
                       input logic [`VLEN-1:0] vs2, input logic [`XLEN-1:0] rs1,
                       input logic [`UOP_INDEX_WIDTH-1:0] idx, input logic [2:0] valids);
    logic [`VLEN:0] expected;
    bit             ok;
    @(negedge clk);
    uop_valid = 1'b1;
    funct6 = f6;
    funct3 = f3;
    vxrm = rm;
    vs2_eew = eew;
    vs1_data = vs1;
    vs2_data = vs2;
    rs1_data = rs1;
    uop_index = idx;
    rob_entry = $urandom;
    {vs1_valid, vs2_valid, rs1_valid} = valids;
    ok = valids[1] && ((f3 == OPIVV) ? valids[2] : valids[0]);
    ok = ok && (f6 inside {VSLL, VSRL, VSRA, VSSRL, VSSRA, VNSRL, VNSRA, VNCLIPU, VNCLIP});
    ok = ok && !((f6 inside {VNSRL, VNSRA, VNCLIPU, VNCLIP}) && (eew == EEW8));
    if (ok) begin
      expected = model(f6, f3, rm, eew, vs1, vs2, rs1, idx);
      exp_data.push_back(expected[`VLEN-1:0]);
      exp_sat.push_back(expected[`VLEN]);
      exp_rob.push_back(rob_entry);
      exp_due.push_back(cyc + 1);
    end
    uops_run++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    start_errors = errors;
  endtask

  task automatic end_test(input int n);
    @(negedge clk);
    uop_valid = 1'b0;
    while (exp_due.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    $display("test %-10s %0d micro-ops, %0d errors", test_name, n, errors - start_errors);
    tests_run++;
  endtask

  // outputs are compared half a cycle after the edge that updates them
  always @(negedge clk) begin : check_results
    bit due_now;
    due_now = (exp_due.size() != 0) && (exp_due[0] == cyc);
    if (!rst) begin
      assert (result_valid || !due_now)
      else begin
        $display("missing result for an accepted micro-op in test %s", test_name);
        errors++;
      end
      assert (!result_valid || due_now)
      else begin
        $display("result without an accepted micro-op in test %s", test_name);
        errors++;
      end
      if (result_valid && due_now) begin
        assert (w_data === exp_data[0])
        else begin
          $display("** Error: %s w_data expected %h actual %h", test_name, exp_data[0], w_data);
          errors++;
        end
        assert (vxsat === exp_sat[0])
        else begin
          $display("** Error: %s vxsat expected %b actual %b", test_name, exp_sat[0], vxsat);
          errors++;
        end
        assert (result_rob_entry === exp_rob[0])
        else begin
          $display("** Error: %s rob entry expected %h actual %h", test_name, exp_rob[0],
                   result_rob_entry);
          errors++;
        end
      end
      if (due_now) begin
        void'(exp_data.pop_front());
        void'(exp_sat.pop_front());
        void'(exp_rob.pop_front());
        void'(exp_due.pop_front());
      end
    end
  end

  initial begin
    #watchdog_ns;
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    opi_funct3_e   f3;
    eew_e          eew;
    shift_funct6_e f6;
    bit            sgn;
    void'($urandom(32'habf2_d138));
    rst = 1'b1;
    uop_valid = 1'b0;
    funct3 = OPIVV;
    funct6 = VSLL;
    vxrm = RNU;
    vs2_eew = EEW8;
    vs1_data = '0;
    vs1_valid = 1'b0;
    vs2_data = '0;
    vs2_valid = 1'b0;
    rs1_data = '0;
    rs1_valid = 1'b0;
    uop_index = '0;
    rob_entry = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    start_test("plain");
    for (int i = 0; i < n_plain; i++) begin
      issue(plain_ops[$urandom_range(2)], forms[$urandom_range(2)], RNU,
            widths[$urandom_range(2)], rand_vec(), rand_vec(), $urandom, 3'($urandom), 3'b111);
    end
    end_test(n_plain);

    start_test("scaling");
    for (int i = 0; i < n_scaling; i++) begin
      f6 = $urandom_range(1) ? VSSRA : VSSRL;
      issue(f6, forms[$urandom_range(2)], vxrm_e'(i % 4), widths[$urandom_range(2)],
            rand_vec(), rand_vec(), $urandom, 3'($urandom), 3'b111);
    end
    end_test(n_scaling);

    start_test("narrow");
    for (int i = 0; i < n_narrow; i++) begin
      f6 = $urandom_range(1) ? VNSRA : VNSRL;
      eew = $urandom_range(1) ? EEW32 : EEW16;
      issue(f6, forms[$urandom_range(2)], RNU, eew, rand_vec(), rand_vec(), $urandom,
            3'(i), 3'b111);
    end
    end_test(n_narrow);

    // even iterations are out of range and odd ones in range with a zero shift
    start_test("clip");
    for (int i = 0; i < n_clip; i++) begin
      sgn = $urandom_range(1);
      eew = $urandom_range(1) ? EEW32 : EEW16;
      issue(sgn ? VNCLIP : VNCLIPU, OPIVX, vxrm_e'($urandom_range(3)), eew, rand_vec(),
            clip_operand(eew, sgn, (i % 2) == 0), 32'd0, 3'($urandom), 3'b111);
    end
    end_test(n_clip);

    start_test("reject");
    for (int i = 0; i < n_reject; i++) begin
      f3 = forms[$urandom_range(2)];
      case ($urandom_range(4))
        0: issue(plain_ops[$urandom_range(2)], f3, RNU, widths[$urandom_range(2)],
                 rand_vec(), rand_vec(), $urandom, 3'($urandom), 3'b111);
        1: issue($urandom_range(1) ? VNSRL : VNCLIP, f3, RNU, EEW8, rand_vec(), rand_vec(),
                 $urandom, 3'($urandom), 3'b111);
        2: issue(VSRA, f3, RNE, widths[$urandom_range(2)], rand_vec(), rand_vec(),
                 $urandom, 3'($urandom), 3'b101);
        3: issue(VSSRL, f3, ROD, EEW16, rand_vec(), rand_vec(), $urandom, 3'($urandom),
                 (f3 == OPIVV) ? 3'b011 : 3'b110);
        default: issue(shift_funct6_e'(6'b000000), f3, RNU, EEW32, rand_vec(), rand_vec(),
                       $urandom, 3'($urandom), 3'b111);
      endcase
    end
    end_test(n_reject);

    $display("tests %0d, micro-ops %0d, errors %0d, property failures %0d",
             tests_run, uops_run, errors, u_dut.u_props.failures);
    if (errors == 0 && u_dut.u_props.failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/rvv_shift_pkg.sv
hw/shift_uop_decode.sv
hw/shift_lane.sv
hw/shift_narrow_clip.sv
hw/shift_result_pack.sv
hw/rvv_shift_unit.sv
sim/rvv_shift_unit_properties.sv
sim/rvv_shift_unit_tb.sv

//--- Bender.yml
package:
  name: rvv_shift_unit

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rvv_shift_pkg.sv
      - hw/shift_uop_decode.sv
      - hw/shift_lane.sv
      - hw/shift_narrow_clip.sv
      - hw/shift_result_pack.sv
      - hw/rvv_shift_unit.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/rvv_shift_unit_properties.sv
      - sim/rvv_shift_unit_tb.sv
